/* mips_pkg.sv */
package mips_pkg;

   localparam int NB_WORD      = 32;
   localparam int NB_REG_ADDR  = 5;
   localparam int N_REGS       = 32;
   localparam int NB_IMEM_ADDR = 8;
   localparam int NB_DMEM_ADDR = 8;
   localparam int NB_IMM       = 16;
   localparam int NB_OPCODE    = 6;
   localparam int NB_FUNCT     = 6;

   // Field positions inside the instruction word
   localparam int MSB_RS = 25;
   localparam int MSB_RT = 20;
   localparam int MSB_RD = 15;

   localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
   localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'h08;
   localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
   localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2b;
   localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;
   localparam logic [NB_OPCODE-1:0] OP_BNE   = 6'h05;
   localparam logic [NB_OPCODE-1:0] OP_HALT  = 6'h3f;

   localparam logic [NB_FUNCT-1:0] FN_ADDU = 6'h21;
   localparam logic [NB_FUNCT-1:0] FN_SUBU = 6'h23;
   localparam logic [NB_FUNCT-1:0] FN_AND  = 6'h24;
   localparam logic [NB_FUNCT-1:0] FN_OR   = 6'h25;
   localparam logic [NB_FUNCT-1:0] FN_SLT  = 6'h2a;

   typedef logic [NB_WORD-1:0]      word_t;
   typedef logic [NB_REG_ADDR-1:0]  reg_addr_t;
   typedef logic [NB_IMEM_ADDR-1:0] imem_addr_t;
   typedef logic [NB_DMEM_ADDR-1:0] dmem_addr_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

   // Operand source: register value, EX/MEM result or writeback value
   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_MEM,
      FWD_WB
   } fwd_sel_e;

endpackage

/* pipeline_ifs.sv */
`timescale 1ns/100ps

interface id_ex_if import mips_pkg::*; ();
   word_t     a;
   word_t     b;
   word_t     imm;
   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t dest;
   alu_op_e   alu_op;
   logic      use_imm;
   logic      mem_read;
   logic      mem_write;
   logic      reg_write;
   logic      halt;

   modport source (output a, b, imm, rs, rt, dest, alu_op, use_imm,
                   mem_read, mem_write, reg_write, halt);
   modport sink (input a, b, imm, rs, rt, dest, alu_op, use_imm,
                 mem_read, mem_write, reg_write, halt);
   modport monitor (input rs, rt, dest, mem_read, reg_write);
endinterface

interface ex_mem_if import mips_pkg::*; ();
   word_t     alu_result;
   word_t     store_data;
   reg_addr_t dest;
   logic      mem_read;
   logic      mem_write;
   logic      reg_write;
   logic      halt;

   modport source (output alu_result, store_data, dest, mem_read, mem_write, reg_write, halt);
   modport sink (input alu_result, store_data, dest, mem_read, mem_write, reg_write, halt);
   modport monitor (input dest, mem_read, reg_write);
endinterface

/* instruction_fetch.sv */
`timescale 1ns/100ps

module instruction_fetch import mips_pkg::*; (
   input  logic       i_clock,
   input  logic       reset,
   input  logic       i_run,
   input  logic       i_stall,
   input  logic       i_halt,
   input  logic       i_branch_taken,
   input  imem_addr_t i_branch_target,
   input  logic       i_prog_we,
   input  imem_addr_t i_prog_addr,
   input  word_t      i_prog_data,
   output word_t      o_instr,
   output imem_addr_t o_pc_next
);

   word_t      imem [2**NB_IMEM_ADDR];
   imem_addr_t pc;
   imem_addr_t pc_inc;
   logic       advance;

   assign pc_inc  = pc + 1'b1;
   assign advance = i_run & ~i_stall & ~i_halt;

   // Host loads the program only while the core is idle
   always_ff @(posedge i_clock) begin
      if (i_prog_we && !i_run) begin
         imem[i_prog_addr] <= i_prog_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         pc      <= '0;
         o_instr <= '0;
      end else if (advance) begin
         pc <= i_branch_taken ? i_branch_target : pc_inc;
         // Squash the word fetched behind a taken branch
         o_instr <= i_branch_taken ? '0 : imem[pc];
      end else if (!i_stall || !i_run || i_halt) begin
         o_instr <= '0;
      end
   end

   always_ff @(posedge i_clock) begin
      if (advance) begin
         o_pc_next <= pc_inc;
      end
   end

endmodule

/* instruction_decode.sv */
`timescale 1ns/100ps

module instruction_decode import mips_pkg::*; (
   input  logic       i_clock,
   input  logic       reset,
   input  word_t      i_instr,
   input  imem_addr_t i_pc_next,
   input  logic       i_stall,
   input  logic       i_wb_we,
   input  reg_addr_t  i_wb_addr,
   input  word_t      i_wb_data,
   input  fwd_sel_e   i_br_fwd_a,
   input  fwd_sel_e   i_br_fwd_b,
   input  word_t      i_mem_fwd_data,
   output logic       o_branch_taken,
   output imem_addr_t o_branch_target,
   output logic       o_is_branch,
   id_ex_if.source    id_ex
);

   word_t               regs [N_REGS];
   logic [NB_OPCODE-1:0] opcode;
   logic [NB_FUNCT-1:0]  funct;
   reg_addr_t           rs;
   reg_addr_t           rt;
   reg_addr_t           rd;
   word_t               imm_ext;
   word_t               rf_a;
   word_t               rf_b;
   word_t               br_a;
   word_t               br_b;
   alu_op_e             ctl_alu_op;
   reg_addr_t           ctl_dest;
   logic                ctl_use_imm;
   logic                ctl_mem_read;
   logic                ctl_mem_write;
   logic                ctl_reg_write;
   logic                ctl_halt;
   logic                halted;
   logic                issue;

   assign opcode  = i_instr[NB_WORD-1 -: NB_OPCODE];
   assign funct   = i_instr[NB_FUNCT-1:0];
   assign rs      = i_instr[MSB_RS -: NB_REG_ADDR];
   assign rt      = i_instr[MSB_RT -: NB_REG_ADDR];
   assign rd      = i_instr[MSB_RD -: NB_REG_ADDR];
   assign imm_ext = {{(NB_WORD-NB_IMM){i_instr[NB_IMM-1]}}, i_instr[NB_IMM-1:0]};

   always_comb begin
      ctl_alu_op    = ALU_ADD;
      ctl_dest      = rd;
      ctl_use_imm   = 1'b0;
      ctl_mem_read  = 1'b0;
      ctl_mem_write = 1'b0;
      ctl_reg_write = 1'b0;
      ctl_halt      = 1'b0;
      o_is_branch   = 1'b0;
      case (opcode)
         OP_RTYPE: begin
            ctl_reg_write = 1'b1;
            case (funct)
               FN_ADDU: ctl_alu_op = ALU_ADD;
               FN_SUBU: ctl_alu_op = ALU_SUB;
               FN_AND:  ctl_alu_op = ALU_AND;
               FN_OR:   ctl_alu_op = ALU_OR;
               FN_SLT:  ctl_alu_op = ALU_SLT;
               // Unknown function codes, the all-zero no-op among them
               default: ctl_reg_write = 1'b0;
            endcase
         end
         OP_ADDI: begin
            ctl_dest      = rt;
            ctl_use_imm   = 1'b1;
            ctl_reg_write = 1'b1;
         end
         OP_LW: begin
            ctl_dest      = rt;
            ctl_use_imm   = 1'b1;
            ctl_mem_read  = 1'b1;
            ctl_reg_write = 1'b1;
         end
         OP_SW: begin
            ctl_use_imm   = 1'b1;
            ctl_mem_write = 1'b1;
         end
         OP_BEQ, OP_BNE: o_is_branch = 1'b1;
         OP_HALT:        ctl_halt    = 1'b1;
         default: ;
      endcase
   end

   // Written on the falling edge so decode reads the new value in the same cycle
   always_ff @(negedge i_clock) begin
      if (i_wb_we && i_wb_addr != '0) begin
         regs[i_wb_addr] <= i_wb_data;
      end
   end

   assign rf_a = (rs == '0) ? '0 : regs[rs];
   assign rf_b = (rt == '0) ? '0 : regs[rt];

   always_comb begin
      case (i_br_fwd_a)
         FWD_MEM: br_a = i_mem_fwd_data;
         FWD_WB:  br_a = i_wb_data;
         default: br_a = rf_a;
      endcase
      case (i_br_fwd_b)
         FWD_MEM: br_b = i_mem_fwd_data;
         FWD_WB:  br_b = i_wb_data;
         default: br_b = rf_b;
      endcase
   end

   assign o_branch_target = i_pc_next + imm_ext[NB_IMEM_ADDR-1:0];
   assign o_branch_taken  = o_is_branch & ~halted &
                            ((opcode == OP_BEQ) ? (br_a == br_b) : (br_a != br_b));

   // Nothing behind a halt is issued
   assign issue = ~i_stall & ~halted;

   always_ff @(posedge i_clock) begin
      if (reset) begin
         halted <= 1'b0;
      end else if (ctl_halt && issue) begin
         halted <= 1'b1;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         id_ex.mem_read  <= 1'b0;
         id_ex.mem_write <= 1'b0;
         id_ex.reg_write <= 1'b0;
         id_ex.halt      <= 1'b0;
      end else begin
         id_ex.mem_read  <= ctl_mem_read & issue;
         id_ex.mem_write <= ctl_mem_write & issue;
         id_ex.reg_write <= ctl_reg_write & issue;
         id_ex.halt      <= ctl_halt & issue;
      end
   end

   always_ff @(posedge i_clock) begin
      id_ex.a       <= rf_a;
      id_ex.b       <= rf_b;
      id_ex.imm     <= imm_ext;
      id_ex.rs      <= rs;
      id_ex.rt      <= rt;
      id_ex.dest    <= ctl_dest;
      id_ex.alu_op  <= ctl_alu_op;
      id_ex.use_imm <= ctl_use_imm;
   end

endmodule

/* execution.sv */
`timescale 1ns/100ps

module execution import mips_pkg::*; (
   input  logic     i_clock,
   input  logic     reset,
   id_ex_if.sink    id_ex,
   input  fwd_sel_e i_fwd_a_sel,
   input  fwd_sel_e i_fwd_b_sel,
   input  word_t    i_wb_data,
   ex_mem_if.source ex_mem
);

   word_t op_a;
   word_t op_b_reg;
   word_t op_b;
   word_t result;

   function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                     word_t wb_val);
      case (sel)
         FWD_MEM: return mem_val;
         FWD_WB:  return wb_val;
         default: return reg_val;
      endcase
   endfunction

   assign op_a     = fwd_mux(i_fwd_a_sel, id_ex.a, ex_mem.alu_result, i_wb_data);
   assign op_b_reg = fwd_mux(i_fwd_b_sel, id_ex.b, ex_mem.alu_result, i_wb_data);
   // addi, lw and sw take the immediate
   assign op_b     = id_ex.use_imm ? id_ex.imm : op_b_reg;

   always_comb begin
      case (id_ex.alu_op)
         ALU_ADD: result = op_a + op_b;
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_SLT: result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
         default: result = '0;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         ex_mem.mem_read  <= 1'b0;
         ex_mem.mem_write <= 1'b0;
         ex_mem.reg_write <= 1'b0;
         ex_mem.halt      <= 1'b0;
      end else begin
         ex_mem.mem_read  <= id_ex.mem_read;
         ex_mem.mem_write <= id_ex.mem_write;
         ex_mem.reg_write <= id_ex.reg_write;
         ex_mem.halt      <= id_ex.halt;
      end
   end

   always_ff @(posedge i_clock) begin
      ex_mem.alu_result <= result;
      ex_mem.store_data <= op_b_reg;
      ex_mem.dest       <= id_ex.dest;
   end

endmodule

/* memory_access.sv */
`timescale 1ns/100ps

module memory_access import mips_pkg::*; (
   input  logic       i_clock,
   input  logic       reset,
   ex_mem_if.sink     ex_mem,
   input  dmem_addr_t i_dbg_addr,
   output word_t      o_dbg_data,
   output logic       o_wb_we,
   output reg_addr_t  o_wb_addr,
   output word_t      o_wb_data,
   output logic       o_halt
);

   word_t      dmem [2**NB_DMEM_ADDR];
   dmem_addr_t addr;
   logic       wb_halt;

   // Data addresses count words
   assign addr = ex_mem.alu_result[NB_DMEM_ADDR-1:0];

   always_ff @(posedge i_clock) begin
      if (ex_mem.mem_write) begin
         dmem[addr] <= ex_mem.store_data;
      end
   end

   // Host read port
   always_ff @(posedge i_clock) begin
      o_dbg_data <= dmem[i_dbg_addr];
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_wb_we <= 1'b0;
         wb_halt <= 1'b0;
      end else begin
         o_wb_we <= ex_mem.reg_write;
         wb_halt <= ex_mem.halt;
      end
   end

   always_ff @(posedge i_clock) begin
      o_wb_addr <= ex_mem.dest;
      o_wb_data <= ex_mem.mem_read ? dmem[addr] : ex_mem.alu_result;
   end

   // Sticky until reset
   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_halt <= 1'b0;
      end else if (wb_halt) begin
         o_halt <= 1'b1;
      end
   end

endmodule

/* hazard_forward_unit.sv */
`timescale 1ns/100ps

module hazard_forward_unit import mips_pkg::*; (
   input  word_t     i_instr,
   input  logic      i_is_branch,
   id_ex_if.monitor  id_ex,
   ex_mem_if.monitor ex_mem,
   input  logic      i_wb_we,
   input  reg_addr_t i_wb_addr,
   output logic      o_stall,
   output fwd_sel_e  o_fwd_a_sel,
   output fwd_sel_e  o_fwd_b_sel,
   output fwd_sel_e  o_br_fwd_a,
   output fwd_sel_e  o_br_fwd_b
);

   logic [NB_OPCODE-1:0] opcode;
   reg_addr_t            rs;
   reg_addr_t            rt;
   logic                 uses_rt;
   logic                 mem_alu_we;
   logic                 load_use;
   logic                 branch_wait;

   // Younger EX/MEM result wins over writeback
   function automatic fwd_sel_e pick_src(reg_addr_t src, logic mem_we, reg_addr_t mem_dst,
                                         logic wb_we, reg_addr_t wb_dst);
      if (src == '0) return FWD_NONE;
      if (mem_we && mem_dst == src) return FWD_MEM;
      if (wb_we && wb_dst == src) return FWD_WB;
      return FWD_NONE;
   endfunction

   function automatic logic depends(reg_addr_t dst, reg_addr_t src_a, reg_addr_t src_b,
                                    logic use_b);
      return (dst != '0) && (dst == src_a || (use_b && dst == src_b));
   endfunction

   assign opcode  = i_instr[NB_WORD-1 -: NB_OPCODE];
   assign rs      = i_instr[MSB_RS -: NB_REG_ADDR];
   assign rt      = i_instr[MSB_RT -: NB_REG_ADDR];
   assign uses_rt = (opcode == OP_RTYPE) || (opcode == OP_SW) ||
                    (opcode == OP_BEQ) || (opcode == OP_BNE);

   assign o_fwd_a_sel = pick_src(id_ex.rs, ex_mem.reg_write, ex_mem.dest, i_wb_we, i_wb_addr);
   assign o_fwd_b_sel = pick_src(id_ex.rt, ex_mem.reg_write, ex_mem.dest, i_wb_we, i_wb_addr);

   // A load in EX/MEM has no data yet, so the branch waits instead
   assign mem_alu_we = ex_mem.reg_write & ~ex_mem.mem_read;
   assign o_br_fwd_a = pick_src(rs, mem_alu_we, ex_mem.dest, i_wb_we, i_wb_addr);
   assign o_br_fwd_b = pick_src(rt, mem_alu_we, ex_mem.dest, i_wb_we, i_wb_addr);

   assign load_use    = id_ex.mem_read & depends(id_ex.dest, rs, rt, uses_rt);
   assign branch_wait = i_is_branch &
                        ((id_ex.reg_write & depends(id_ex.dest, rs, rt, uses_rt)) |
                         (ex_mem.mem_read & depends(ex_mem.dest, rs, rt, uses_rt)));
   assign o_stall     = load_use | branch_wait;

endmodule

/* pipeline.sv */
`timescale 1ns/100ps

module pipeline import mips_pkg::*; (
   input  logic       i_clock,
   input  logic       reset,
   input  logic       i_prog_we,
   input  imem_addr_t i_prog_addr,
   input  word_t      i_prog_data,
   input  logic       i_run,
   input  dmem_addr_t i_dbg_addr,
   output word_t      o_dbg_data,
   output logic       o_halt
);

   word_t      instr;
   imem_addr_t pc_next;
   logic       branch_taken;
   imem_addr_t branch_target;
   logic       is_branch;
   logic       stall;
   fwd_sel_e   fwd_a_sel;
   fwd_sel_e   fwd_b_sel;
   fwd_sel_e   br_fwd_a;
   fwd_sel_e   br_fwd_b;
   logic       wb_we;
   reg_addr_t  wb_addr;
   word_t      wb_data;

   id_ex_if  id_ex_bus ();
   ex_mem_if ex_mem_bus ();

   instruction_fetch u_instruction_fetch (
      .i_clock         (i_clock),
      .reset           (reset),
      .i_run           (i_run),
      .i_stall         (stall),
      .i_halt          (o_halt),
      .i_branch_taken  (branch_taken),
      .i_branch_target (branch_target),
      .i_prog_we       (i_prog_we),
      .i_prog_addr     (i_prog_addr),
      .i_prog_data     (i_prog_data),
      .o_instr         (instr),
      .o_pc_next       (pc_next)
   );

   instruction_decode u_instruction_decode (
      .i_clock         (i_clock),
      .reset           (reset),
      .i_instr         (instr),
      .i_pc_next       (pc_next),
      .i_stall         (stall),
      .i_wb_we         (wb_we),
      .i_wb_addr       (wb_addr),
      .i_wb_data       (wb_data),
      .i_br_fwd_a      (br_fwd_a),
      .i_br_fwd_b      (br_fwd_b),
      .i_mem_fwd_data  (ex_mem_bus.alu_result),
      .o_branch_taken  (branch_taken),
      .o_branch_target (branch_target),
      .o_is_branch     (is_branch),
      .id_ex           (id_ex_bus)
   );

   execution u_execution (
      .i_clock     (i_clock),
      .reset       (reset),
      .id_ex       (id_ex_bus),
      .i_fwd_a_sel (fwd_a_sel),
      .i_fwd_b_sel (fwd_b_sel),
      .i_wb_data   (wb_data),
      .ex_mem      (ex_mem_bus)
   );

   memory_access u_memory_access (
      .i_clock    (i_clock),
      .reset      (reset),
      .ex_mem     (ex_mem_bus),
      .i_dbg_addr (i_dbg_addr),
      .o_dbg_data (o_dbg_data),
      .o_wb_we    (wb_we),
      .o_wb_addr  (wb_addr),
      .o_wb_data  (wb_data),
      .o_halt     (o_halt)
   );

   hazard_forward_unit u_hazard_forward_unit (
      .i_instr     (instr),
      .i_is_branch (is_branch),
      .id_ex       (id_ex_bus),
      .ex_mem      (ex_mem_bus),
      .i_wb_we     (wb_we),
      .i_wb_addr   (wb_addr),
      .o_stall     (stall),
      .o_fwd_a_sel (fwd_a_sel),
      .o_fwd_b_sel (fwd_b_sel),
      .o_br_fwd_a  (br_fwd_a),
      .o_br_fwd_b  (br_fwd_b)
   );

endmodule

/* pipeline_checker.sv */
`timescale 1ns/100ps

module pipeline_checker import mips_pkg::*; (
   input logic  i_clock,
   input logic  reset,
   input logic  o_halt,
   input word_t o_dbg_data
);

   // Reset clears halt, and nothing can raise it in the first free cycle
   halt_low_after_reset: assert property (@(posedge i_clock)
      ($past(reset) || $past(reset, 2)) |-> !o_halt)
      else $error("o_halt high during reset or in the cycle after it");

   // Halt is sticky
   halt_sticky: assert property (@(posedge i_clock) $fell(o_halt) |-> $past(reset))
      else $error("o_halt fell while reset was low");

   // Host reads happen once the core has halted
   dbg_data_known: assert property (@(posedge i_clock) $past(o_halt) |-> !$isunknown(o_dbg_data))
      else $error("o_dbg_data unknown one cycle after a host read");

endmodule

bind pipeline pipeline_checker u_pipeline_checker (
   .i_clock    (i_clock),
   .reset      (reset),
   .o_halt     (o_halt),
   .o_dbg_data (o_dbg_data)
);

/* tb_pipeline.sv */
`timescale 1ns/100ps

module tb_pipeline import mips_pkg::*; ();

   logic        i_clock;
   logic        reset;
   logic        i_prog_we;
   imem_addr_t  i_prog_addr;
   word_t       i_prog_data;
   logic        i_run;
   dmem_addr_t  i_dbg_addr;
   word_t       o_dbg_data;
   logic        o_halt;

   // Each entry is tag, address and data word
   logic [43:0] stim [128];
   logic [31:0] rng;
   int          n_stim;
   int          n_prog;
   int          limit;
   int          cycles = 0;
   int          n_tests;
   int          n_errors;

   pipeline dut (.*);

   initial begin
      i_clock = 1'b0;
      forever #50 i_clock = ~i_clock;
   end

   always @(posedge i_clock) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("Timeout: the run did not end within %0d cycles", limit);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] next_random(logic [31:0] state);
      logic [31:0] s;
      s = state;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic load_stim();
      for (int i = 0; i < 128; i++) begin
         stim[i] = '0;
      end
      $readmemh("program_stim.txt", stim);
      n_stim = 0;
      n_prog = 0;
      // A zero tag marks the end of the file
      while (n_stim < 128 && stim[n_stim][43:40] != 4'h0) begin
         if (stim[n_stim][43:40] == 4'hc) begin
            n_prog++;
         end
         n_stim++;
      end
   endtask

   task automatic write_program();
      int gap;
      for (int i = 0; i < n_stim; i++) begin
         if (stim[i][43:40] == 4'hc) begin
            @(posedge i_clock);
            i_prog_we   <= 1'b1;
            i_prog_addr <= stim[i][39:32];
            i_prog_data <= stim[i][31:0];
            @(posedge i_clock);
            i_prog_we <= 1'b0;
            rng = next_random(rng);
            gap = int'(rng[1:0]);
            repeat (gap) @(posedge i_clock);
         end
      end
   endtask

   task automatic run_to_halt();
      int start;
      @(negedge i_clock);
      n_tests++;
      if (o_halt !== 1'b0) begin
         n_errors++;
         $display("[FAIL] %0d ns: o_halt high before the run", $time);
      end else begin
         $display("[PASS] o_halt low after reset");
      end
      @(posedge i_clock);
      i_run <= 1'b1;
      start = cycles;
      @(negedge i_clock);
      while (o_halt !== 1'b1) begin
         @(negedge i_clock);
      end
      n_tests++;
      // Halt must hold while the core sits idle
      repeat (4) @(negedge i_clock);
      if (o_halt !== 1'b1) begin
         n_errors++;
         $display("[FAIL] %0d ns: o_halt fell after the halt", $time);
      end else begin
         $display("[PASS] halt reached %0d cycles after run", cycles - start - 4);
      end
   endtask

   task automatic reset_after_halt();
      @(posedge i_clock);
      reset <= 1'b1;
      i_run <= 1'b0;
      repeat (3) @(posedge i_clock);
      reset <= 1'b0;
      @(negedge i_clock);
      n_tests++;
      if (o_halt !== 1'b0) begin
         n_errors++;
         $display("[FAIL] %0d ns: o_halt still high after reset", $time);
      end else begin
         $display("[PASS] o_halt cleared by reset");
      end
   endtask

   task automatic check_word(dmem_addr_t addr, word_t expected);
      @(posedge i_clock);
      i_dbg_addr <= addr;
      @(posedge i_clock);
      @(negedge i_clock);
      n_tests++;
      if (o_dbg_data !== expected) begin
         n_errors++;
         $display("[FAIL] %0d ns: mem[%0d] reads %h, expected %h",
                  $time, addr, o_dbg_data, expected);
      end else begin
         $display("[PASS] mem[%0d] = %h", addr, o_dbg_data);
      end
   endtask

   task automatic check_memory();
      for (int i = 0; i < n_stim; i++) begin
         if (stim[i][43:40] == 4'he) begin
            check_word(stim[i][39:32], stim[i][31:0]);
         end
      end
   endtask

   initial begin
      reset       <= 1'b1;
      i_prog_we   <= 1'b0;
      i_prog_addr <= '0;
      i_prog_data <= '0;
      i_run       <= 1'b0;
      i_dbg_addr  <= '0;
      rng = 32'hbbf2_675f;
      n_tests = 0;
      n_errors = 0;
      load_stim();
      limit = 20 * n_prog + 200;
      repeat (3) @(posedge i_clock);
      reset <= 1'b0;
      write_program();
      run_to_halt();
      check_memory();
      // Data memory keeps its contents through reset
      reset_after_halt();
      check_memory();
      $display("Tests: %0d, passed: %0d, failed: %0d", n_tests, n_tests - n_errors, n_errors);
      if (n_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* sources.f */
mips_pkg.sv
pipeline_ifs.sv
instruction_fetch.sv
instruction_decode.sv
execution.sv
memory_access.sv
hazard_forward_unit.sv
pipeline.sv
pipeline_checker.sv
tb_pipeline.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --assert -Wno-fatal --top-module tb_pipeline -f sources.f \
   && ./obj_dir/Vtb_pipeline; } > sim.log 2>&1 || echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

/* program_stim.txt */
// Tag c: program word. Columns: tag, instruction memory address, instruction
// Tag e: expected word. Columns: tag, data memory address, value after halt
c_00_20010007 // addi $1, $0, 7
c_01_2002fffd // addi $2, $0, -3
c_02_2003000c // addi $3, $0, 12
c_03_00232021 // addu $4, $1, $3
c_04_00232823 // subu $5, $1, $3
c_05_00233024 // and  $6, $1, $3
c_06_00233825 // or   $7, $1, $3
c_07_0041402a // slt  $8, $2, $1
c_08_0022482a // slt  $9, $1, $2
c_09_ac040000 // sw $4, 0($0)
c_0a_ac050001 // sw $5, 1($0)
c_0b_ac060002 // sw $6, 2($0)
c_0c_ac070003 // sw $7, 3($0)
c_0d_ac080004 // sw $8, 4($0)
c_0e_ac090005 // sw $9, 5($0)
c_0f_00845021 // addu $10, $4, $4
c_10_01415821 // addu $11, $10, $1
c_11_016a6023 // subu $12, $11, $10
c_12_ac0c0006 // sw $12, 6($0)
c_13_8c0d0000 // lw $13, 0($0)
c_14_01a17021 // addu $14, $13, $1
c_15_ac0e0007 // sw $14, 7($0)
c_16_ac030008 // sw $3, 8($0)
c_17_ac030009 // sw $3, 9($0)
c_18_200f001a // addi $15, $0, 26
c_19_11ee0002 // beq $15, $14, +2
c_1a_ac010008 // sw $1, 8($0)
c_1b_ac010009 // sw $1, 9($0)
c_1c_ac03000a // sw $3, 10($0)
c_1d_8c100001 // lw $16, 1($0)
c_1e_16050001 // bne $16, $5, +1
c_1f_ac02000b // sw $2, 11($0)
c_20_ac01000c // sw $1, 12($0)
c_21_ac03000d // sw $3, 13($0)
c_22_fc000000 // halt
c_23_ac01000d // sw $1, 13($0)
e_00_00000013 // addu
e_01_fffffffb // subu
e_02_00000004 // and
e_03_0000000f // or
e_04_00000001 // slt true
e_05_00000000 // slt false
e_06_00000007 // forwarded chain
e_07_0000001a // load-use sum
e_08_0000000c // squashed store
e_09_0000000c // skipped store
e_0a_0000000c // beq target
e_0b_fffffffd // bne fall-through
e_0c_00000007
e_0d_0000000c // store after halt
